/* Makefile */
VERILATOR  ?= verilator
TOP        ?= fpu_tb
FLIST      ?= flist.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then \
		echo "Test run FAILED, see $(LOG)"; exit 1; \
	elif ! grep -q "Simulation completed successfully" $(LOG); then \
		echo "Test run ended without a result, see $(LOG)"; exit 1; \
	else \
		echo "Test run passed"; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* flist.f */
rtl/fpu_pkg.sv
rtl/fpu_decode.sv
rtl/fpu_regfile.sv
rtl/fp_addsub.sv
rtl/fp_mult.sv
rtl/fp_convert.sv
rtl/fpu_writeback.sv
rtl/fpu_top.sv
test/fpu_tb.sv

/* rtl/fp_addsub.sv */
`timescale 1ns/100ps
`default_nettype none

module fp_addsub (
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire logic [31:0] a,
    input  wire logic [31:0] b,
    input  wire logic        sub,
    output logic [31:0]      sum
);

    localparam int ew = fpu_pkg::exp_bits;
    localparam int mw = fpu_pkg::man_bits;
    localparam int xw = ew + 2;  // Signed exponent with headroom.

    logic          b_sign;
    logic          a_big;
    logic [ew-1:0] e_big;
    logic [ew-1:0] e_small;
    logic [ew-1:0] e_diff;
    logic [mw:0]   m_big;
    logic [mw:0]   m_small;

    logic          s1_sign;
    logic          s1_sub;
    logic [ew-1:0] s1_exp;
    logic [mw:0]   s1_m_big;
    logic [mw:0]   s1_m_small;

    logic          s2_sign;
    logic [ew-1:0] s2_exp;
    logic [mw+1:0] s2_sum;

    logic [4:0]           lz;
    logic [mw:0]          shl;
    logic signed [xw-1:0] norm_e;
    logic [mw-1:0]        norm_m;
    logic [31:0]          result;

    // Hidden bit restored, subnormals read as zero.
    function automatic logic [mw:0] unpack(input logic [31:0] f);
        return (f[mw +: ew] == '0) ? '0 : {1'b1, f[mw-1:0]};
    endfunction

    function automatic logic [4:0] lzc(input logic [mw:0] v);
        logic [4:0] n;
        n = 5'(mw + 1);
        for (int i = 0; i <= mw; i++) begin
            if (v[i]) begin
                n = 5'(mw - i);
            end
        end
        return n;
    endfunction

    always_comb begin
        b_sign  = b[31] ^ sub;
        a_big   = a[30:0] >= b[30:0];
        e_big   = a_big ? a[mw +: ew] : b[mw +: ew];
        e_small = a_big ? b[mw +: ew] : a[mw +: ew];
        m_big   = a_big ? unpack(a) : unpack(b);
        m_small = a_big ? unpack(b) : unpack(a);
        e_diff  = e_big - e_small;
    end

    // Normalization of the stage 2 sum.
    always_comb begin
        lz  = lzc(s2_sum[mw:0]);
        shl = s2_sum[mw:0] << lz;
        if (s2_sum[mw+1]) begin  // Carry out, shift right by one.
            norm_e = xw'(s2_exp) + xw'(1);
            norm_m = s2_sum[mw:1];
        end else begin
            norm_e = xw'(s2_exp) - xw'(lz);
            norm_m = shl[mw-1:0];
        end
        if (s2_sum == '0 || norm_e <= 0) begin
            result = '0;  // Exact cancellation gives +0.
        end else if (norm_e >= (2 ** ew) - 1) begin
            result = {s2_sign, {ew{1'b1}}, {mw{1'b0}}};
        end else begin
            result = {s2_sign, norm_e[ew-1:0], norm_m};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_sign <= 1'b0;
            s1_sub  <= 1'b0;
            s1_exp  <= '0;
            s2_sign <= 1'b0;
            s2_exp  <= '0;
            sum     <= '0;
        end else begin
            s1_sign <= a_big ? a[31] : b_sign;
            s1_sub  <= a[31] ^ b_sign;
            s1_exp  <= e_big;
            s2_sign <= s1_sign;
            s2_exp  <= s1_exp;
            sum     <= result;
        end
    end

    always_ff @(posedge clk) begin
        s1_m_big   <= m_big;
        s1_m_small <= m_small >> e_diff;  // Bits shifted out are dropped.
        s2_sum     <= s1_sub ? {1'b0, s1_m_big} - {1'b0, s1_m_small}
                             : {1'b0, s1_m_big} + {1'b0, s1_m_small};
    end

endmodule

`default_nettype wire

/* rtl/fp_convert.sv */
`timescale 1ns/100ps
`default_nettype none

module fp_convert (
    input  wire logic [31:0] fval,
    output logic [31:0]      to_int,
    input  wire logic [31:0] ival,
    output logic [31:0]      to_float
);

    localparam int ew = fpu_pkg::exp_bits;
    localparam int mw = fpu_pkg::man_bits;

    logic [ew-1:0]  f_exp;
    logic [4:0]     f_shift;
    logic [mw+31:0] f_wide;
    logic [31:0]    f_mag;

    logic [31:0] i_abs;
    logic [4:0]  i_msb;
    logic [31:0] i_norm;

    function automatic logic [4:0] msb(input logic [31:0] v);
        logic [4:0] n;
        n = 5'd0;
        for (int i = 0; i < 32; i++) begin
            if (v[i]) begin
                n = 5'(i);
            end
        end
        return n;
    endfunction

    // Float to int, truncating toward zero.
    always_comb begin
        f_exp   = fval[mw +: ew];
        f_shift = 5'(f_exp - ew'(fpu_pkg::exp_bias));
        f_wide  = {31'b0, 1'b1, fval[mw-1:0]} << f_shift;
        f_mag   = f_wide[mw +: 32];
        if (f_exp < fpu_pkg::exp_bias) begin
            to_int = '0;  // Magnitude below one.
        end else if (f_exp >= fpu_pkg::exp_bias + 31) begin
            to_int = fval[31] ? 32'h8000_0000 : 32'h7fff_ffff;
        end else begin
            to_int = fval[31] ? -f_mag : f_mag;
        end
    end

    // Int to float. The most negative value still has its magnitude in 32 bits.
    always_comb begin
        i_abs  = ival[31] ? -ival : ival;
        i_msb  = msb(i_abs);
        i_norm = i_abs << (5'd31 - i_msb);  // Leading one to bit 31.
        if (i_abs == '0) begin
            to_float = '0;
        end else begin
            to_float = {ival[31], ew'(fpu_pkg::exp_bias + int'(i_msb)), i_norm[30 -: mw]};
        end
    end

endmodule

`default_nettype wire

/* rtl/fp_mult.sv */
`timescale 1ns/100ps
`default_nettype none

module fp_mult (
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire logic [31:0] a,
    input  wire logic [31:0] b,
    output logic [31:0]      prod
);

    localparam int ew   = fpu_pkg::exp_bits;
    localparam int mw   = fpu_pkg::man_bits;
    localparam int xw   = ew + 2;
    localparam int half = (mw + 1) / 2;
    localparam int pw   = 2 * (mw + 1);

    logic                 s1_sign, s2_sign, s3_sign, s4_sign;
    logic                 s1_zero, s2_zero, s3_zero, s4_zero;
    logic signed [xw-1:0] s1_exp, s2_exp, s3_exp, s4_exp;

    logic [mw:0]        s1_ma;
    logic [mw:0]        s1_mb;
    logic [mw:0]        s2_ma;
    logic [mw-half:0]   s2_mb_hi;
    logic [mw+half:0]   s2_lo;
    logic [pw-1:0]      s3_prod;
    logic [mw-1:0]      s4_man;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            {s1_sign, s2_sign, s3_sign, s4_sign} <= '0;
            {s1_zero, s2_zero, s3_zero, s4_zero} <= '0;
            s1_exp <= '0;
            s2_exp <= '0;
            s3_exp <= '0;
            s4_exp <= '0;
            prod   <= '0;
        end else begin
            s1_sign <= a[31] ^ b[31];
            s1_zero <= (a[mw +: ew] == '0) || (b[mw +: ew] == '0);  // Subnormals flush.
            s1_exp  <= xw'(a[mw +: ew]) + xw'(b[mw +: ew]) - xw'(fpu_pkg::exp_bias);
            s2_sign <= s1_sign;
            s2_zero <= s1_zero;
            s2_exp  <= s1_exp;
            s3_sign <= s2_sign;
            s3_zero <= s2_zero;
            s3_exp  <= s2_exp;
            s4_sign <= s3_sign;
            s4_zero <= s3_zero;
            s4_exp  <= s3_prod[pw-1] ? s3_exp + xw'(1) : s3_exp;
            if (s4_zero || s4_exp <= 0) begin
                prod <= '0;
            end else if (s4_exp >= (2 ** ew) - 1) begin
                prod <= {s4_sign, {ew{1'b1}}, {mw{1'b0}}};  // Saturate to infinity.
            end else begin
                prod <= {s4_sign, s4_exp[ew-1:0], s4_man};
            end
        end
    end

    // Mantissa datapath, product built from two half-width partial products.
    always_ff @(posedge clk) begin
        s1_ma    <= {1'b1, a[mw-1:0]};
        s1_mb    <= {1'b1, b[mw-1:0]};
        s2_ma    <= s1_ma;
        s2_mb_hi <= s1_mb[mw:half];
        s2_lo    <= s1_ma * s1_mb[half-1:0];
        s3_prod  <= pw'(s2_lo) + ((pw'(s2_ma) * pw'(s2_mb_hi)) << half);
        s4_man   <= s3_prod[pw-1] ? s3_prod[pw-2 -: mw] : s3_prod[pw-3 -: mw];
    end

endmodule

`default_nettype wire

/* rtl/fpu_decode.sv */
`timescale 1ns/100ps
`default_nettype none

module fpu_decode (
    input  wire logic [31:0]       inst,
    output fpu_pkg::fpu_ctrl_t     ctrl,
    output logic [4:0]             rs1,
    output logic [4:0]             rs2
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [1:0] fmt;
    logic [4:0] funct5;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign fmt    = inst[26:25];
    assign funct5 = inst[31:27];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];

    always_comb begin
        ctrl    = '0;  // op_none, no write.
        ctrl.rd = inst[11:7];
        case (opcode)
            fpu_pkg::opc_load_fp: begin
                if (funct3 == 3'b010) begin  // Word width only.
                    ctrl.op        = fpu_pkg::op_load;
                    ctrl.reg_write = 1'b1;
                end
            end
            fpu_pkg::opc_store_fp: begin
                if (funct3 == 3'b010) begin
                    ctrl.op = fpu_pkg::op_store;
                end
            end
            fpu_pkg::opc_op_fp: begin
                if (fmt == 2'b00) begin  // Single precision.
                    case (funct5)
                        fpu_pkg::funct5_add: begin
                            ctrl.op        = fpu_pkg::op_add;
                            ctrl.reg_write = 1'b1;
                        end
                        fpu_pkg::funct5_sub: begin
                            ctrl.op        = fpu_pkg::op_sub;
                            ctrl.reg_write = 1'b1;
                        end
                        fpu_pkg::funct5_mul: begin
                            ctrl.op        = fpu_pkg::op_mul;
                            ctrl.reg_write = 1'b1;
                        end
                        fpu_pkg::funct5_cvt_w_s: begin
                            if (rs2 == 5'd0) begin  // Signed variant only.
                                ctrl.op = fpu_pkg::op_cvt_w_s;
                            end
                        end
                        fpu_pkg::funct5_cvt_s_w: begin
                            if (rs2 == 5'd0) begin
                                ctrl.op        = fpu_pkg::op_cvt_s_w;
                                ctrl.reg_write = 1'b1;
                            end
                        end
                        default: ctrl.op = fpu_pkg::op_none;
                    endcase
                end
            end
            default: ctrl.op = fpu_pkg::op_none;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/fpu_pkg.sv */
`default_nettype none

package fpu_pkg;

    // Single-precision field layout.
    localparam int exp_bits = 8;
    localparam int man_bits = 23;
    localparam int exp_bias = 127;

    localparam logic [6:0] opc_load_fp  = 7'b0000111;  // flw
    localparam logic [6:0] opc_store_fp = 7'b0100111;  // fsw
    localparam logic [6:0] opc_op_fp    = 7'b1010011;

    // Values of inst[31:27] under OP-FP.
    localparam logic [4:0] funct5_add     = 5'b00000;
    localparam logic [4:0] funct5_sub     = 5'b00001;
    localparam logic [4:0] funct5_mul     = 5'b00010;
    localparam logic [4:0] funct5_cvt_w_s = 5'b11000;
    localparam logic [4:0] funct5_cvt_s_w = 5'b11010;

    typedef enum logic [2:0] {
        op_none,
        op_load,
        op_store,
        op_add,
        op_sub,
        op_mul,
        op_cvt_w_s,
        op_cvt_s_w
    } fpu_op_e;

    // Carried alongside each instruction down the result pipeline.
    typedef struct packed {
        logic       reg_write;
        fpu_op_e    op;
        logic [4:0] rd;
    } fpu_ctrl_t;

endpackage

`default_nettype wire

/* rtl/fpu_regfile.sv */
`timescale 1ns/100ps
`default_nettype none

module fpu_regfile (
    input  wire logic        clk,
    input  wire logic [4:0]  rs1,
    input  wire logic [4:0]  rs2,
    output logic [31:0]      rdata1,
    output logic [31:0]      rdata2,
    input  wire logic        we,
    input  wire logic [4:0]  waddr,
    input  wire logic [31:0] wdata
);

    logic [31:0] regs [32];

    // Reads are combinational so operands are ready in the issue cycle.
    assign rdata1 = regs[rs1];
    assign rdata2 = regs[rs2];

    always_ff @(posedge clk) begin
        if (we) begin
            regs[waddr] <= wdata;
        end
    end

endmodule

`default_nettype wire

/* rtl/fpu_top.sv */
`timescale 1ns/100ps
`default_nettype none

module fpu_top (
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire logic [31:0] inst,
    input  wire logic [31:0] from_intreg,
    input  wire logic [31:0] from_mem,
    output logic [31:0]      to_mem,
    output logic [31:0]      to_intreg
);

    fpu_pkg::fpu_ctrl_t ctrl;
    logic [4:0]         rs1;
    logic [4:0]         rs2;
    logic [31:0]        rdata1;
    logic [31:0]        rdata2;
    logic               is_sub;
    logic [31:0]        addsub_out;
    logic [31:0]        mul_out;
    logic [31:0]        cvt_out;
    logic               we;
    logic [4:0]         waddr;
    logic [31:0]        wdata;

    assign is_sub = (ctrl.op == fpu_pkg::op_sub);
    assign to_mem = rdata2;

    fpu_decode u_decode (
        .inst (inst),
        .ctrl (ctrl),
        .rs1  (rs1),
        .rs2  (rs2)
    );

    fpu_regfile u_regfile (
        .clk    (clk),
        .rs1    (rs1),
        .rs2    (rs2),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .we     (we),
        .waddr  (waddr),
        .wdata  (wdata)
    );

    fp_addsub u_addsub (
        .clk   (clk),
        .rst_n (rst_n),
        .a     (rdata1),
        .b     (rdata2),
        .sub   (is_sub),
        .sum   (addsub_out)
    );

    fp_mult u_mult (
        .clk   (clk),
        .rst_n (rst_n),
        .a     (rdata1),
        .b     (rdata2),
        .prod  (mul_out)
    );

    fp_convert u_convert (
        .fval     (rdata1),
        .to_int   (to_intreg),
        .ival     (from_intreg),
        .to_float (cvt_out)
    );

    fpu_writeback u_writeback (
        .clk         (clk),
        .rst_n       (rst_n),
        .ctrl        (ctrl),
        .cvt_data    (cvt_out),
        .mem_data    (from_mem),
        .addsub_data (addsub_out),
        .mul_data    (mul_out),
        .we          (we),
        .waddr       (waddr),
        .wdata       (wdata)
    );

endmodule

`default_nettype wire

/* rtl/fpu_writeback.sv */
`timescale 1ns/100ps
`default_nettype none

module fpu_writeback (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire fpu_pkg::fpu_ctrl_t  ctrl,
    input  wire logic [31:0]         cvt_data,
    input  wire logic [31:0]         mem_data,
    input  wire logic [31:0]         addsub_data,
    input  wire logic [31:0]         mul_data,
    output logic                     we,
    output logic [4:0]               waddr,
    output logic [31:0]              wdata
);

    fpu_pkg::fpu_ctrl_t ctrl_q [5];
    logic [31:0]        res_q  [5];
    logic               is_addsub;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 5; i++) begin
                ctrl_q[i] <= '0;
            end
        end else begin
            ctrl_q[0] <= ctrl;
            for (int i = 1; i < 5; i++) begin
                ctrl_q[i] <= ctrl_q[i-1];
            end
        end
    end

    // The adder result is valid in the cycle after E2, while its op sits in stage 3.
    assign is_addsub = (ctrl_q[2].op == fpu_pkg::op_add) || (ctrl_q[2].op == fpu_pkg::op_sub);

    always_ff @(posedge clk) begin
        res_q[0] <= cvt_data;
        res_q[1] <= (ctrl_q[0].op == fpu_pkg::op_load) ? mem_data : res_q[0];
        res_q[2] <= res_q[1];
        res_q[3] <= is_addsub ? addsub_data : res_q[2];
        res_q[4] <= res_q[3];
    end

    assign we    = ctrl_q[4].reg_write;
    assign waddr = ctrl_q[4].rd;
    assign wdata = (ctrl_q[4].op == fpu_pkg::op_mul) ? mul_data : res_q[4];  // Product arrives last.

endmodule

`default_nettype wire

/* test/fpu_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module fpu_tb;

    typedef enum logic [1:0] {
        chk_none,
        chk_to_mem,
        chk_to_intreg
    } check_e;

    // One row of the stimulus table.
    typedef struct packed {
        logic [31:0] inst;
        logic [31:0] intreg;
        logic [31:0] mem;       // Driven in the cycle after inst.
        check_e      kind;
        logic [31:0] expected;
    } vector_t;

    localparam int drive_delay = 2;

    // RISC-V funct5 codes under OP-FP.
    localparam logic [4:0] fadd_f5    = 5'b00000;
    localparam logic [4:0] fsub_f5    = 5'b00001;
    localparam logic [4:0] fmul_f5    = 5'b00010;
    localparam logic [4:0] fcvt_ws_f5 = 5'b11000;
    localparam logic [4:0] fcvt_sw_f5 = 5'b11010;

    localparam logic [31:0] f_1p0    = 32'h3f80_0000;
    localparam logic [31:0] f_1p5    = 32'h3fc0_0000;
    localparam logic [31:0] f_2p25   = 32'h4010_0000;
    localparam logic [31:0] f_3p75   = 32'h4070_0000;
    localparam logic [31:0] f_4p0    = 32'h4080_0000;
    localparam logic [31:0] f_m2p0   = 32'hc000_0000;
    localparam logic [31:0] f_m3p0   = 32'hc040_0000;
    localparam logic [31:0] f_m3p75  = 32'hc070_0000;
    localparam logic [31:0] f_7p0    = 32'h40e0_0000;
    localparam logic [31:0] f_m12p0  = 32'hc140_0000;
    localparam logic [31:0] f_2pow40 = 32'h5380_0000;
    localparam logic [31:0] marker   = 32'h1234_5678;

    logic        clk;
    logic        rst_n;
    logic [31:0] inst;
    logic [31:0] from_intreg;
    logic [31:0] from_mem;
    logic [31:0] to_mem;
    logic [31:0] to_intreg;

    vector_t vectors [$];
    string   names [$];
    integer  seed;
    int      cycles = 0;
    int      cycle_limit = 0;
    int      pass_count = 0;
    int      error_count = 0;

    fpu_top dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .inst        (inst),
        .from_intreg (from_intreg),
        .from_mem    (from_mem),
        .to_mem      (to_mem),
        .to_intreg   (to_intreg)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Timeout after %0d cycles, the table did not run to its end.", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic logic [31:0] flw_word(input logic [4:0] rd);
        return {12'h000, 5'd0, 3'b010, rd, 7'b0000111};
    endfunction

    function automatic logic [31:0] fsw_word(input logic [4:0] rs2);
        return {7'h00, rs2, 5'd0, 3'b010, 5'h00, 7'b0100111};
    endfunction

    // Round mode field set to RTZ.
    function automatic logic [31:0] opfp_word(input logic [4:0] funct5, input logic [4:0] rd,
                                              input logic [4:0] rs1, input logic [4:0] rs2);
        return {funct5, 2'b00, rs2, rs1, 3'b001, rd, 7'b1010011};
    endfunction

    task automatic add_step(input string name, input logic [31:0] inst_word,
                            input logic [31:0] intreg, input logic [31:0] mem,
                            input check_e kind, input logic [31:0] expected);
        vector_t v;
        v.inst     = inst_word;
        v.intreg   = intreg;
        v.mem      = mem;
        v.kind     = kind;
        v.expected = expected;
        names.push_back(name);
        vectors.push_back(v);
    endtask

    task automatic add_idles(input int count);
        for (int i = 0; i < count; i++) begin
            add_step("idle", 32'h0, 32'h0, 32'h0, chk_none, 32'h0);
        end
    endtask

    task automatic build_table();
        logic [31:0] rnd [4];
        add_step("load f1", flw_word(5'd1), 32'h0, f_1p5, chk_none, 32'h0);
        add_step("load f2", flw_word(5'd2), 32'h0, f_2p25, chk_none, 32'h0);
        add_step("load f3", flw_word(5'd3), 32'h0, f_m2p0, chk_none, 32'h0);
        add_step("load f4", flw_word(5'd4), 32'h0, f_4p0, chk_none, 32'h0);
        add_step("load f5", flw_word(5'd5), 32'h0, f_1p0, chk_none, 32'h0);
        add_step("load f6", flw_word(5'd6), 32'h0, 32'h0, chk_none, 32'h0);
        add_step("load f7", flw_word(5'd7), 32'h0, f_m3p75, chk_none, 32'h0);
        add_step("load f8", flw_word(5'd8), 32'h0, f_2pow40, chk_none, 32'h0);
        add_step("load f20", flw_word(5'd20), 32'h0, marker, chk_none, 32'h0);
        for (int k = 0; k < 4; k++) begin
            rnd[k] = $random(seed);
            add_step($sformatf("load f%0d random", 24 + k), flw_word(5'(24 + k)),
                     32'h0, rnd[k], chk_none, 32'h0);
        end
        add_idles(6);
        add_step("flw/fsw f1", fsw_word(5'd1), 32'h0, 32'h0, chk_to_mem, f_1p5);
        add_step("flw/fsw f3", fsw_word(5'd3), 32'h0, 32'h0, chk_to_mem, f_m2p0);
        add_step("flw/fsw f20", fsw_word(5'd20), 32'h0, 32'h0, chk_to_mem, marker);
        for (int k = 0; k < 4; k++) begin
            add_step($sformatf("flw/fsw f%0d random", 24 + k), fsw_word(5'(24 + k)),
                     32'h0, 32'h0, chk_to_mem, rnd[k]);
        end

        // Arithmetic and conversions on the loaded operands.
        add_step("fadd f9", opfp_word(fadd_f5, 5'd9, 5'd1, 5'd2), 32'h0, 32'h0, chk_none, 32'h0);
        add_step("fsub f10", opfp_word(fsub_f5, 5'd10, 5'd5, 5'd4), 32'h0, 32'h0, chk_none, 32'h0);
        add_step("fsub f11", opfp_word(fsub_f5, 5'd11, 5'd1, 5'd1), 32'h0, 32'h0, chk_none, 32'h0);
        add_step("fmul f12", opfp_word(fmul_f5, 5'd12, 5'd1, 5'd3), 32'h0, 32'h0, chk_none, 32'h0);
        add_step("fmul f13", opfp_word(fmul_f5, 5'd13, 5'd1, 5'd6), 32'h0, 32'h0, chk_none, 32'h0);
        add_step("fcvt.s.w f14", opfp_word(fcvt_sw_f5, 5'd14, 5'd0, 5'd0), 32'd7, 32'h0,
                 chk_none, 32'h0);
        add_step("fcvt.s.w f15", opfp_word(fcvt_sw_f5, 5'd15, 5'd0, 5'd0), -32'sd12, 32'h0,
                 chk_none, 32'h0);
        // The rd field points at f20, which must keep its marker.
        add_step("fcvt.w.s -3.75", opfp_word(fcvt_ws_f5, 5'd20, 5'd7, 5'd0), 32'h0, 32'h0,
                 chk_to_intreg, 32'hffff_fffd);
        add_step("fcvt.w.s 2^40", opfp_word(fcvt_ws_f5, 5'd20, 5'd8, 5'd0), 32'h0, 32'h0,
                 chk_to_intreg, 32'h7fff_ffff);
        add_idles(6);
        add_step("fadd 1.5+2.25", fsw_word(5'd9), 32'h0, 32'h0, chk_to_mem, f_3p75);
        add_step("fsub 1.0-4.0", fsw_word(5'd10), 32'h0, 32'h0, chk_to_mem, f_m3p0);
        add_step("fsub x-x", fsw_word(5'd11), 32'h0, 32'h0, chk_to_mem, 32'h0);
        add_step("fmul 1.5*-2.0", fsw_word(5'd12), 32'h0, 32'h0, chk_to_mem, f_m3p0);
        add_step("fmul 1.5*0.0", fsw_word(5'd13), 32'h0, 32'h0, chk_to_mem, 32'h0);
        add_step("fcvt.s.w 7", fsw_word(5'd14), 32'h0, 32'h0, chk_to_mem, f_7p0);
        add_step("fcvt.s.w -12", fsw_word(5'd15), 32'h0, 32'h0, chk_to_mem, f_m12p0);

        // Unrecognized words in the pipeline must not write anything.
        add_step("load f21", flw_word(5'd21), 32'h0, f_m2p0, chk_none, 32'h0);
        add_step("zero word", 32'h0000_0000, 32'h0, 32'h0, chk_none, 32'h0);
        add_step("integer add", 32'h0020_8a33, 32'h0, 32'h0, chk_none, 32'h0);  // rd is 20.
        add_idles(6);
        add_step("f20 not overwritten", fsw_word(5'd20), 32'h0, 32'h0, chk_to_mem, marker);
        add_step("f21 loaded", fsw_word(5'd21), 32'h0, 32'h0, chk_to_mem, f_m2p0);

        // Five writes in flight at once.
        add_step("issue fadd f16", opfp_word(fadd_f5, 5'd16, 5'd2, 5'd1), 32'h0, 32'h0,
                 chk_none, 32'h0);
        add_step("issue fmul f17", opfp_word(fmul_f5, 5'd17, 5'd3, 5'd1), 32'h0, 32'h0,
                 chk_none, 32'h0);
        add_step("issue flw f18", flw_word(5'd18), 32'h0, f_2pow40, chk_none, 32'h0);
        add_step("issue fcvt f19", opfp_word(fcvt_sw_f5, 5'd19, 5'd0, 5'd0), 32'd7, 32'h0,
                 chk_none, 32'h0);
        add_step("issue fsub f22", opfp_word(fsub_f5, 5'd22, 5'd5, 5'd4), 32'h0, 32'h0,
                 chk_none, 32'h0);
        add_idles(6);
        add_step("in flight fadd", fsw_word(5'd16), 32'h0, 32'h0, chk_to_mem, f_3p75);
        add_step("in flight fmul", fsw_word(5'd17), 32'h0, 32'h0, chk_to_mem, f_m3p0);
        add_step("in flight flw", fsw_word(5'd18), 32'h0, 32'h0, chk_to_mem, f_2pow40);
        add_step("in flight fcvt", fsw_word(5'd19), 32'h0, 32'h0, chk_to_mem, f_7p0);
        add_step("in flight fsub", fsw_word(5'd22), 32'h0, 32'h0, chk_to_mem, f_m3p0);
    endtask

    task automatic check_output(input string name, input check_e kind,
                                input logic [31:0] expected);
        logic [31:0] actual;
        actual = (kind == chk_to_mem) ? to_mem : to_intreg;
        assert (actual === expected) begin
            pass_count++;
            $display("PASS    %s", name);
        end else begin
            error_count++;
            $display("[ERROR] %s expected %08h actual %08h", name, expected, actual);
        end
    endtask

    // Outputs are combinational in the issue cycle, sampled at the falling edge.
    task automatic run_table();
        for (int i = 0; i <= vectors.size(); i++) begin
            @(posedge clk);
            #(drive_delay);
            if (i < vectors.size()) begin
                inst        = vectors[i].inst;
                from_intreg = vectors[i].intreg;
            end else begin
                inst        = 32'h0;
                from_intreg = 32'h0;
            end
            if (i > 0) begin
                from_mem = vectors[i-1].mem;
            end
            if (i < vectors.size() && vectors[i].kind != chk_none) begin
                @(negedge clk);
                check_output(names[i], vectors[i].kind, vectors[i].expected);
            end
        end
    endtask

    initial begin
        seed        = 32;
        rst_n       = 1'b0;
        inst        = 32'h0;
        from_intreg = 32'h0;
        from_mem    = 32'h0;
        build_table();
        cycle_limit = vectors.size() * 8 + 50;
        repeat (3) @(posedge clk);
        #(drive_delay);
        rst_n = 1'b1;
        run_table();
        $display("Checks passed: %0d, failed: %0d", pass_count, error_count);
        if (error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
